/* source/fifo_pkg.sv */
//****************************************
// Shared sizes and vector types for the synchronous FIFO
// Imported by the RTL and by the testbench checkers
//****************************************

`default_nettype none

package fifo_pkg;

   // RAM geometry
   localparam int ADDR_W = 6;                 // Address bits
   localparam int DATA_W = 16;                // Word width
   localparam int DEPTH  = 1 << ADDR_W;       // 64 words

   // Fill count needs one extra bit to hold DEPTH itself
   localparam int COUNT_W = ADDR_W + 1;

   // Status thresholds
   localparam int ALMOST_FULL_LVL  = 56;      // Set at or above
   localparam int ALMOST_EMPTY_LVL = 8;       // Set at or below

   // RAM address
   typedef logic [ADDR_W-1:0] addr_t;

   // One stored word
   typedef logic [DATA_W-1:0] data_t;

   // Words held, 0 to DEPTH
   typedef logic [COUNT_W-1:0] count_t;

endpackage : fifo_pkg

`default_nettype wire

/* source/tpsram_rbw.sv */
//****************************************
// Two-port synchronous RAM, read-before-write on port A
// Port A reads and writes, port X only reads
// Both ports give registered data one cycle after enable
//****************************************

`timescale 1ns/1ps
`default_nettype none

module tpsram_rbw
   import fifo_pkg::*;
(
   input  logic   clk_i,

   // Port A, read/write
   input  logic   a_en_i,      // Chip select
   input  logic   a_we_i,      // Write enable, only with a_en_i
   input  addr_t  a_addr_i,
   input  data_t  a_data_i,
   output data_t  a_data_o,    // Old word at a_addr_i

   // Port X, read only
   input  logic   x_en_i,      // Chip select
   input  addr_t  x_addr_i,
   output data_t  x_data_o
);

   // Storage array, no reset so it maps onto block RAM
   data_t mem [DEPTH];

   // Output registers of both ports
   data_t a_rd_q;
   data_t x_rd_q;

   // Port A
   // Read and write on the same edge
   // The read sees the word from before the write
   always_ff @(posedge clk_i) begin
      if (a_en_i) begin
         a_rd_q <= mem[a_addr_i];          // Old contents
         if (a_we_i) begin
            mem[a_addr_i] <= a_data_i;     // New contents
         end
      end
   end

   // Port X
   // Holds its last word while not enabled
   always_ff @(posedge clk_i) begin
      if (x_en_i) begin
         x_rd_q <= mem[x_addr_i];
      end
   end

   // Registered outputs straight out
   assign a_data_o = a_rd_q;
   assign x_data_o = x_rd_q;

endmodule : tpsram_rbw

`default_nettype wire

/* source/fifo_ctrl.sv */
//****************************************
// FIFO controller for the single-clock FIFO
// Pointers, fill count, status and sticky error flags
// Drives both RAM ports and the read-valid pulse
//****************************************

`timescale 1ns/1ps
`default_nettype none

module fifo_ctrl
   import fifo_pkg::*;
(
   input  logic   clk_i,
   input  logic   reset_i,         // Sync, active high

   // Requests, one cycle each
   input  logic   push_i,
   input  logic   pop_i,

   // RAM write port
   output logic   wr_en_o,
   output addr_t  wr_addr_o,

   // RAM read port
   output logic   rd_en_o,
   output addr_t  rd_addr_o,

   // One cycle after an accepted pop
   output logic   rd_valid_o,

   // Status
   output count_t count_o,
   output logic   full_o,
   output logic   empty_o,
   output logic   almost_full_o,
   output logic   almost_empty_o,

   // Sticky until reset
   output logic   overflow_o,
   output logic   underflow_o
);

   // Accept decisions
   logic   push_ok;
   logic   pop_ok;

   // Pointers, wrap at DEPTH by width alone
   addr_t  wr_ptr_q;
   addr_t  rd_ptr_q;

   // Fill count
   count_t count_q;
   count_t count_next;

   // Flags and their next values
   logic   full_q;
   logic   empty_q;
   logic   afull_q;
   logic   aempty_q;
   logic   full_next;
   logic   empty_next;
   logic   afull_next;
   logic   aempty_next;

   // Error flags
   logic   overflow_q;
   logic   underflow_q;

   // Delayed pop for the data-valid pulse
   logic   rd_valid_q;

   // Acceptance uses only registered flags
   // So a pop at empty is refused even with a push alongside
   // and a push at full is refused even with a pop alongside
   assign push_ok = push_i & ~full_q;
   assign pop_ok  = pop_i & ~empty_q;

   // Next fill count
   always_comb begin
      unique case ({push_ok, pop_ok})
         2'b10:   count_next = count_q + count_t'(1);   // Push only
         2'b01:   count_next = count_q - count_t'(1);   // Pop only
         default: count_next = count_q;                  // Both or neither
      endcase
   end

   // Flags from the next count
   // Registered below, so never a cycle behind the count
   always_comb begin
      full_next   = (count_next == count_t'(DEPTH));
      empty_next  = (count_next == '0);
      afull_next  = (count_next >= count_t'(ALMOST_FULL_LVL));
      aempty_next = (count_next <= count_t'(ALMOST_EMPTY_LVL));
   end

   // Write pointer
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_ptr_q <= '0;
      end else if (push_ok) begin
         wr_ptr_q <= wr_ptr_q + addr_t'(1);    // Wraps 63 to 0
      end
   end

   // Read pointer
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rd_ptr_q <= '0;
      end else if (pop_ok) begin
         rd_ptr_q <= rd_ptr_q + addr_t'(1);
      end
   end

   // Count and status flags
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         count_q  <= '0;
         full_q   <= 1'b0;
         empty_q  <= 1'b1;         // Empty out of reset
         afull_q  <= 1'b0;
         aempty_q <= 1'b1;         // Zero is below the low mark
      end else begin
         count_q  <= count_next;
         full_q   <= full_next;
         empty_q  <= empty_next;
         afull_q  <= afull_next;
         aempty_q <= aempty_next;
      end
   end

   // Sticky errors
   // Set by any refused request, cleared only by reset
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         overflow_q  <= 1'b0;
         underflow_q <= 1'b0;
      end else begin
         if (push_i && full_q) begin
            overflow_q <= 1'b1;     // Push dropped
         end
         if (pop_i && empty_q) begin
            underflow_q <= 1'b1;    // Pop dropped
         end
      end
   end

   // RAM read data lands one cycle after the pop
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rd_valid_q <= 1'b0;
      end else begin
         rd_valid_q <= pop_ok;
      end
   end

   // RAM ports
   assign wr_en_o   = push_ok;
   assign wr_addr_o = wr_ptr_q;
   assign rd_en_o   = pop_ok;
   assign rd_addr_o = rd_ptr_q;

   // Registered outputs
   assign rd_valid_o     = rd_valid_q;
   assign count_o        = count_q;
   assign full_o         = full_q;
   assign empty_o        = empty_q;
   assign almost_full_o  = afull_q;
   assign almost_empty_o = aempty_q;
   assign overflow_o     = overflow_q;
   assign underflow_o    = underflow_q;

endmodule : fifo_ctrl

`default_nettype wire

/* source/sync_fifo.sv */
//****************************************
// Single-clock FIFO top, 64 words of 16 bits
// Push with push_i, pop with pop_i, data follows with rd_valid_o
//****************************************

`timescale 1ns/1ps
`default_nettype none

module sync_fifo
   import fifo_pkg::*;
(
   input  logic   clk_i,
   input  logic   reset_i,

   // Writer side
   input  logic   push_i,
   input  data_t  wr_data_i,

   // Reader side
   input  logic   pop_i,
   output data_t  rd_data_o,       // Valid with rd_valid_o, held after
   output logic   rd_valid_o,

   // Status
   output count_t count_o,
   output logic   full_o,
   output logic   empty_o,
   output logic   almost_full_o,
   output logic   almost_empty_o,
   output logic   overflow_o,
   output logic   underflow_o
);

   // Controller to RAM
   logic  wr_en;
   addr_t wr_addr;
   logic  rd_en;
   addr_t rd_addr;

   // Pointers, count and flags
   fifo_ctrl ctrl_i (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .push_i         (push_i),
      .pop_i          (pop_i),
      .wr_en_o        (wr_en),
      .wr_addr_o      (wr_addr),
      .rd_en_o        (rd_en),
      .rd_addr_o      (rd_addr),
      .rd_valid_o     (rd_valid_o),
      .count_o        (count_o),
      .full_o         (full_o),
      .empty_o        (empty_o),
      .almost_full_o  (almost_full_o),
      .almost_empty_o (almost_empty_o),
      .overflow_o     (overflow_o),
      .underflow_o    (underflow_o)
   );

   // Storage
   // Port A only writes here, its read word is not needed
   tpsram_rbw ram_i (
      .clk_i    (clk_i),
      .a_en_i   (wr_en),
      .a_we_i   (wr_en),
      .a_addr_i (wr_addr),
      .a_data_i (wr_data_i),       // Straight from the writer
      .a_data_o (),
      .x_en_i   (rd_en),
      .x_addr_i (rd_addr),
      .x_data_o (rd_data_o)
   );

endmodule : sync_fifo

`default_nettype wire

/* verification/sync_fifo_assertions.sv */
//****************************************
// Checker for the single-clock FIFO, bound to sync_fifo
// Queue reference model plus concurrent assertions
// Failures counted in error_count for the testbench
//****************************************

`timescale 1ns/1ps
`default_nettype none

module sync_fifo_assertions
   import fifo_pkg::*;
(
   input  wire logic   clk_i,
   input  wire logic   reset_i,
   input  wire logic   push_i,
   input  wire data_t  wr_data_i,
   input  wire logic   pop_i,
   input  wire data_t  rd_data_o,      // DUT outputs observed here
   input  wire logic   rd_valid_o,
   input  wire count_t count_o,
   input  wire logic   full_o,
   input  wire logic   empty_o,
   input  wire logic   almost_full_o,
   input  wire logic   almost_empty_o,
   input  wire logic   overflow_o,
   input  wire logic   underflow_o
);

   int     error_count = 0;    // Read by the testbench

   // Reference model state
   data_t  exp_q [$];          // Words the FIFO should hold, oldest first
   count_t exp_count;
   data_t  exp_data;           // Word due with the next valid pulse
   logic   exp_valid;
   logic   exp_overflow;
   logic   exp_underflow;
   logic   m_push;             // Push the model accepts
   logic   m_pop;              // Pop the model accepts

   // Acceptance straight from the model's own fill level
   assign m_push = push_i && (exp_count != count_t'(DEPTH));
   assign m_pop  = pop_i && (exp_count != '0);

   always @(posedge clk_i) begin
      if (reset_i) begin
         exp_q.delete();
         exp_count     <= '0;
         exp_valid     <= 1'b0;
         exp_overflow  <= 1'b0;
         exp_underflow <= 1'b0;
      end else begin
         if (m_pop) begin
            exp_data <= exp_q.pop_front();     // Oldest word out first
         end
         if (m_push) begin
            exp_q.push_back(wr_data_i);
         end
         exp_count <= count_t'(exp_count + count_t'(m_push) - count_t'(m_pop));
         exp_valid <= m_pop;                   // Data one cycle after pop
         if (push_i && !m_push) exp_overflow  <= 1'b1;
         if (pop_i && !m_pop)   exp_underflow <= 1'b1;
      end
   end

   function automatic void flag_error(string msg);
      error_count++;
      $error("%s", msg);
   endfunction

   property p_hold(ok);
      @(posedge clk_i) disable iff (reset_i) ok;
   endproperty

   a_count: assert property (p_hold(count_o == exp_count))
      else flag_error("count_o differs from the model");
   a_full_empty: assert property (p_hold(full_o == (exp_count == count_t'(DEPTH))
                                 && empty_o == (exp_count == '0)))
      else flag_error("full_o or empty_o wrong for the fill level");
   a_almost: assert property (p_hold(
         almost_full_o == (exp_count >= count_t'(ALMOST_FULL_LVL))
         && almost_empty_o == (exp_count <= count_t'(ALMOST_EMPTY_LVL))))
      else flag_error("almost_full_o or almost_empty_o wrong for the fill level");
   a_valid: assert property (p_hold(rd_valid_o == exp_valid))
      else flag_error("rd_valid_o not exactly one cycle after an accepted pop");
   a_data: assert property (p_hold(!rd_valid_o || rd_data_o == exp_data))
      else flag_error("rd_data_o is not the oldest word");
   a_errors: assert property (p_hold(overflow_o == exp_overflow
                                     && underflow_o == exp_underflow))
      else flag_error("overflow_o or underflow_o differs from the model");

   // Sticky until reset
   a_ovf_sticky: assert property (@(posedge clk_i) disable iff (reset_i)
         overflow_o |=> overflow_o)
      else flag_error("overflow_o dropped without reset");
   a_udf_sticky: assert property (@(posedge clk_i) disable iff (reset_i)
         underflow_o |=> underflow_o)
      else flag_error("underflow_o dropped without reset");

   // Refused pop gives no data
   a_udf_no_valid: assert property (@(posedge clk_i) disable iff (reset_i)
         (pop_i && empty_o) |=> !rd_valid_o)
      else flag_error("rd_valid_o pulse after a pop at empty");

endmodule : sync_fifo_assertions

`default_nettype wire

/* verification/sync_fifo_tb.sv */
//****************************************
// Testbench for the single-clock FIFO
// Runs the stimulus phases, the bound checker does the checking
//****************************************

`timescale 1ns/1ps
`default_nettype none

module sync_fifo_tb
   import fifo_pkg::*;
();

   localparam int CLK_PERIOD    = 20;               // ns
   localparam int RANDOM_CYCLES = 600;
   localparam int TOTAL_CYCLES  = 4 * DEPTH + RANDOM_CYCLES + 40;
   localparam int WATCHDOG_NS   = TOTAL_CYCLES * CLK_PERIOD + 2000;   // Plus margin

   // DUT signals
   logic   clk_i;
   logic   reset_i;
   logic   push_i;
   data_t  wr_data_i;
   logic   pop_i;
   data_t  rd_data_o;
   logic   rd_valid_o;
   count_t count_o;
   logic   full_o;
   logic   empty_o;
   logic   almost_full_o;
   logic   almost_empty_o;
   logic   overflow_o;
   logic   underflow_o;

   sync_fifo dut_i (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .push_i         (push_i),
      .wr_data_i      (wr_data_i),
      .pop_i          (pop_i),
      .rd_data_o      (rd_data_o),
      .rd_valid_o     (rd_valid_o),
      .count_o        (count_o),
      .full_o         (full_o),
      .empty_o        (empty_o),
      .almost_full_o  (almost_full_o),
      .almost_empty_o (almost_empty_o),
      .overflow_o     (overflow_o),
      .underflow_o    (underflow_o)
   );

   // Checker inside the DUT scope
   bind sync_fifo sync_fifo_assertions chk_i (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .push_i         (push_i),
      .wr_data_i      (wr_data_i),
      .pop_i          (pop_i),
      .rd_data_o      (rd_data_o),
      .rd_valid_o     (rd_valid_o),
      .count_o        (count_o),
      .full_o         (full_o),
      .empty_o        (empty_o),
      .almost_full_o  (almost_full_o),
      .almost_empty_o (almost_empty_o),
      .overflow_o     (overflow_o),
      .underflow_o    (underflow_o)
   );

   initial clk_i = 1'b0;
   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   // Drive one cycle from a falling edge, return at the next one
   task automatic drive_cycle(input logic push, input logic pop);
      push_i    = push;
      pop_i     = pop;
      wr_data_i = data_t'($urandom);
      @(negedge clk_i);
   endtask

   task automatic apply_reset();
      reset_i = 1'b1;
      push_i  = 1'b0;
      pop_i   = 1'b0;
      repeat (2) @(negedge clk_i);     // Two rising edges in reset
      reset_i = 1'b0;
   endtask

   task automatic fill_until_full();
      while (!full_o) drive_cycle(1'b1, 1'b0);
      drive_cycle(1'b0, 1'b0);
   endtask

   task automatic drain_until_empty();
      while (!empty_o) drive_cycle(1'b0, 1'b1);
      drive_cycle(1'b0, 1'b0);          // Last valid pulse lands here
   endtask

   // Weights out of 4 for push and pop
   task automatic run_random(input int cycles, input int push_w, input int pop_w);
      repeat (cycles) drive_cycle(($urandom % 4) < push_w, ($urandom % 4) < pop_w);
   endtask

   // First checker failure ends the run
   initial begin
      wait (dut_i.chk_i.error_count != 0);
      $display("Fail at %t: assertion failure in sync_fifo_assertions", $realtime);
      $display(">>> FAIL");
      $fatal(1, "Checker reported an error");
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the stimulus did not finish within %0d ns", WATCHDOG_NS);
      $display(">>> FAIL");
      $fatal(1, "Watchdog expired");
   end

   initial begin
      int unsigned seed_draw;

      $timeformat(-9, 0, " ns", 0);
      seed_draw = $urandom(32'h5f15);    // Seeds the thread once
      reset_i   = 1'b1;
      push_i    = 1'b0;
      pop_i     = 1'b0;
      wr_data_i = '0;
      apply_reset();

      fill_until_full();
      repeat (4) drive_cycle(1'b1, 1'b0);   // Dropped pushes
      drive_cycle(1'b1, 1'b1);              // At full only the pop counts
      drive_cycle(1'b1, 1'b0);              // Refill the freed slot
      drive_cycle(1'b0, 1'b0);

      drain_until_empty();
      repeat (4) drive_cycle(1'b0, 1'b1);   // Dropped pops
      drive_cycle(1'b1, 1'b1);              // At empty only the push counts
      drive_cycle(1'b0, 1'b1);
      drive_cycle(1'b0, 1'b0);

      apply_reset();                        // Clears both sticky flags
      @(negedge clk_i);

      // Rise to full and back, middle range on the way
      run_random(RANDOM_CYCLES / 2, 3, 1);
      run_random(RANDOM_CYCLES / 2, 1, 3);
      drain_until_empty();
      repeat (2) drive_cycle(1'b0, 1'b0);

      if (dut_i.chk_i.error_count == 0) begin
         $display(">>> PASS");
         $finish;
      end else begin
         $display("Fail at %t: checker errors at end of run", $realtime);
         $display(">>> FAIL");
         $fatal(1, "Checker reported an error");
      end
   end

endmodule : sync_fifo_tb

`default_nettype wire

/* files.f */
source/fifo_pkg.sv
source/tpsram_rbw.sv
source/fifo_ctrl.sv
source/sync_fifo.sv
verification/sync_fifo_assertions.sv
verification/sync_fifo_tb.sv

/* Bender.yml */
package:
  name: sync_fifo

sources:
  # Design, in compile order
  - source/fifo_pkg.sv
  - source/tpsram_rbw.sv
  - source/fifo_ctrl.sv
  - source/sync_fifo.sv

  # Testbench and bound checker
  - target: test
    files:
      - verification/sync_fifo_assertions.sv
      - verification/sync_fifo_tb.sv
